//--- core_types_pkg.sv
/*
    core-wide register file sizes and the physical register index type
*/
package core_types_pkg;

    // --------------------
    // register file sizes

    // physical registers in the core
    localparam int PR_COUNT = 64;
    // bits needed to name one PR
    localparam int LOG_PR_COUNT = 6;

    // architectural registers
    // PRs below this count are mapped out of reset
    localparam int AR_COUNT = 32;

    // --------------------
    // index types

    // one PR index
    typedef logic [LOG_PR_COUNT-1:0] pr_t;

endpackage

//--- free_list_pkg.sv
/*
    free list geometry: bank count and per-bank depth
*/
package free_list_pkg;

    import core_types_pkg::*;

    // --------------------
    // banking

    // must stay a power of two
    // low PR bits select the bank
    localparam int FREE_LIST_BANK_COUNT = 4;
    // width of a bank select
    localparam int LOG_FREE_LIST_BANK_COUNT = $clog2(FREE_LIST_BANK_COUNT);

    // --------------------
    // depth

    // every PR of one bank class fits in its bank
    localparam int FREE_LIST_BANK_DEPTH = PR_COUNT / FREE_LIST_BANK_COUNT;

endpackage

//--- free_list.sv
/*
    banked free list of physical register indices, one circular buffer per bank
    one push and one pop per bank per cycle, filled with the free PRs at reset
*/
module free_list
    import core_types_pkg::*;
    import free_list_pkg::*;
#(
    parameter int BANK_COUNT = FREE_LIST_BANK_COUNT,
    parameter int PR_COUNT = core_types_pkg::PR_COUNT,
    parameter int AR_COUNT = core_types_pkg::AR_COUNT
) (
    input  logic                  CLK,
    input  logic                  nRST,

    // enqueue side, PRs being freed
    input  logic [BANK_COUNT-1:0] enq_req_valid_by_bank,
    input  pr_t  [BANK_COUNT-1:0] enq_req_PR_by_bank,
    output logic [BANK_COUNT-1:0] enq_resp_ack_by_bank,

    // dequeue side, PRs being allocated
    input  logic [BANK_COUNT-1:0] deq_req_valid_by_bank,
    output pr_t  [BANK_COUNT-1:0] deq_req_PR_by_bank,
    output logic [BANK_COUNT-1:0] deq_resp_ready_by_bank
);

    // --------------------
    // geometry

    // entries per bank
    localparam int DEPTH = PR_COUNT / BANK_COUNT;
    // pointer width, at least one bit
    localparam int LOG_DEPTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // occupancy has to reach DEPTH itself
    localparam int CNT_W = $clog2(DEPTH + 1);
    // free PRs per bank out of reset
    localparam int INIT_COUNT = (PR_COUNT - AR_COUNT) / BANK_COUNT;
    // first free slot after the fill, wraps when the bank starts full
    localparam int INIT_TAIL = INIT_COUNT % DEPTH;

    // circular pointer step, wraps at DEPTH
    // explicit wrap so non power-of-two depths still work
    function automatic logic [LOG_DEPTH-1:0] ptr_inc(input logic [LOG_DEPTH-1:0] ptr);
        if (ptr == LOG_DEPTH'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // --------------------
    // per-bank buffers

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank

        // buffer storage
        pr_t                  mem [DEPTH];
        // oldest entry
        logic [LOG_DEPTH-1:0] head_ptr;
        // next slot to write
        logic [LOG_DEPTH-1:0] tail_ptr;
        // occupancy
        logic [CNT_W-1:0]     count;

        logic                 empty;
        logic                 full;
        logic                 push;
        logic                 pop;

        assign empty = (count == '0);
        assign full  = (count == CNT_W'(DEPTH));

        // ack only while there is room
        // dropped enqueues are simply lost
        assign enq_resp_ack_by_bank[b] = enq_req_valid_by_bank[b] & ~full;

        // head is visible before it is taken
        assign deq_req_PR_by_bank[b]     = mem[head_ptr];
        assign deq_resp_ready_by_bank[b] = ~empty;

        // pop gated by empty, so a push into an empty bank
        // cannot leave in the same cycle
        assign push = enq_resp_ack_by_bank[b];
        assign pop  = deq_req_valid_by_bank[b] & ~empty;

        // pointers and occupancy
        always_ff @(posedge CLK or negedge nRST) begin
            if (!nRST) begin
                head_ptr <= '0;
                tail_ptr <= LOG_DEPTH'(INIT_TAIL);
                count    <= CNT_W'(INIT_COUNT);
            end else begin
                if (push) begin
                    tail_ptr <= ptr_inc(tail_ptr);
                end
                if (pop) begin
                    head_ptr <= ptr_inc(head_ptr);
                end
                // push and pop together leave occupancy alone
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        // storage, reset loads this bank's class in increasing order
        // bank b gets AR_COUNT+b, AR_COUNT+b+BANK_COUNT, ...
        always_ff @(posedge CLK or negedge nRST) begin
            if (!nRST) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[i] <= (i < INIT_COUNT) ? pr_t'(AR_COUNT + b + i * BANK_COUNT) : '0;
                end
            end else if (push) begin
                mem[tail_ptr] <= enq_req_PR_by_bank[b];
            end
        end

        // --------------------
        // checks

        // caller must steer a freed PR to its own bank
        a_enq_bank_class: assert property (
            @(posedge CLK) disable iff (!nRST)
            enq_req_valid_by_bank[b] |-> (int'(enq_req_PR_by_bank[b]) % BANK_COUNT) == b
        );

        // architectural PRs never come back through the free list
        a_enq_not_arch: assert property (
            @(posedge CLK) disable iff (!nRST)
            enq_req_valid_by_bank[b] |-> int'(enq_req_PR_by_bank[b]) >= AR_COUNT
        );

        // ack gating must keep occupancy in range across cycles
        a_count_bound: assert property (
            @(posedge CLK) disable iff (!nRST)
            count <= CNT_W'(DEPTH)
        );

    end

endmodule

//--- free_list_wrapper.sv
/*
    free list top level with a register stage on every input and output
*/
module free_list_wrapper
    import core_types_pkg::*;
    import free_list_pkg::*;
(
    input  logic                            CLK,
    input  logic                            nRST,

    // enqueue request and feedback
    input  logic [FREE_LIST_BANK_COUNT-1:0] next_enq_req_valid_by_bank,
    input  pr_t  [FREE_LIST_BANK_COUNT-1:0] next_enq_req_PR_by_bank,
    output logic [FREE_LIST_BANK_COUNT-1:0] last_enq_resp_ack_by_bank,

    // dequeue request and feedback
    input  logic [FREE_LIST_BANK_COUNT-1:0] next_deq_req_valid_by_bank,
    output pr_t  [FREE_LIST_BANK_COUNT-1:0] last_deq_req_PR_by_bank,
    output logic [FREE_LIST_BANK_COUNT-1:0] last_deq_resp_ready_by_bank
);

    // --------------------
    // registered inputs

    logic [FREE_LIST_BANK_COUNT-1:0] enq_req_valid_by_bank;
    pr_t  [FREE_LIST_BANK_COUNT-1:0] enq_req_PR_by_bank;
    logic [FREE_LIST_BANK_COUNT-1:0] deq_req_valid_by_bank;

    // combinational results of the free list
    logic [FREE_LIST_BANK_COUNT-1:0] enq_resp_ack_by_bank;
    pr_t  [FREE_LIST_BANK_COUNT-1:0] deq_req_PR_by_bank;
    logic [FREE_LIST_BANK_COUNT-1:0] deq_resp_ready_by_bank;

    // --------------------
    // free list

    free_list #(
        .BANK_COUNT (FREE_LIST_BANK_COUNT),
        .PR_COUNT   (PR_COUNT),
        .AR_COUNT   (AR_COUNT)
    ) u_free_list (
        .CLK                    (CLK),
        .nRST                   (nRST),
        .enq_req_valid_by_bank  (enq_req_valid_by_bank),
        .enq_req_PR_by_bank     (enq_req_PR_by_bank),
        .enq_resp_ack_by_bank   (enq_resp_ack_by_bank),
        .deq_req_valid_by_bank  (deq_req_valid_by_bank),
        .deq_req_PR_by_bank     (deq_req_PR_by_bank),
        .deq_resp_ready_by_bank (deq_resp_ready_by_bank)
    );

    // --------------------
    // input stage

    // cuts the path from the outside world into the banks
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_req_valid_by_bank <= '0;
            enq_req_PR_by_bank    <= '0;
            deq_req_valid_by_bank <= '0;
        end else begin
            enq_req_valid_by_bank <= next_enq_req_valid_by_bank;
            enq_req_PR_by_bank    <= next_enq_req_PR_by_bank;
            deq_req_valid_by_bank <= next_deq_req_valid_by_bank;
        end
    end

    // --------------------
    // output stage

    // samples head and ready before this edge's push and pop
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            last_enq_resp_ack_by_bank   <= '0;
            last_deq_req_PR_by_bank     <= '0;
            last_deq_resp_ready_by_bank <= '0;
        end else begin
            last_enq_resp_ack_by_bank   <= enq_resp_ack_by_bank;
            last_deq_req_PR_by_bank     <= deq_req_PR_by_bank;
            last_deq_resp_ready_by_bank <= deq_resp_ready_by_bank;
        end
    end

endmodule

//--- tb_free_list_wrapper.sv
/*
    testbench for the registered free list
    replays a hex trace of per-cycle requests and checks the delayed responses
*/
module tb_free_list_wrapper
    import core_types_pkg::*;
    import free_list_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // --------------------
    // trace layout

    localparam int BANKS = FREE_LIST_BANK_COUNT;
    // lines in free_list_trace.txt
    localparam int LINE_COUNT = 57;

    // field offsets within one trace line
    localparam int F_ENQ_VALID = 0;
    localparam int F_ENQ_PR    = 1;
    localparam int F_DEQ_VALID = 1 + BANKS;
    localparam int F_ACK       = 2 + BANKS;
    localparam int F_HEAD      = 3 + BANKS;
    localparam int F_READY     = 3 + 2 * BANKS;
    localparam int FIELD_COUNT = 4 + 2 * BANKS;

    localparam int RESET_CYCLES   = 16;
    // reset, every line, then some slack
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + LINE_COUNT + 10;

    // --------------------
    // DUT signals

    logic             CLK;
    logic             nRST;
    logic [BANKS-1:0] next_enq_req_valid_by_bank;
    pr_t  [BANKS-1:0] next_enq_req_PR_by_bank;
    logic [BANKS-1:0] next_deq_req_valid_by_bank;
    logic [BANKS-1:0] last_enq_resp_ack_by_bank;
    pr_t  [BANKS-1:0] last_deq_req_PR_by_bank;
    logic [BANKS-1:0] last_deq_resp_ready_by_bank;

    // whole trace, one byte per field
    logic [7:0] trace_mem [LINE_COUNT * FIELD_COUNT];

    // expected results in flight, index 1 is the older line
    logic [BANKS-1:0] exp_ack_q   [2];
    pr_t  [BANKS-1:0] exp_head_q  [2];
    logic [BANKS-1:0] exp_ready_q [2];
    logic             exp_live_q  [2];

    int cycle_count = 0;

    free_list_wrapper u_free_list_wrapper (
        .CLK                         (CLK),
        .nRST                        (nRST),
        .next_enq_req_valid_by_bank  (next_enq_req_valid_by_bank),
        .next_enq_req_PR_by_bank     (next_enq_req_PR_by_bank),
        .last_enq_resp_ack_by_bank   (last_enq_resp_ack_by_bank),
        .next_deq_req_valid_by_bank  (next_deq_req_valid_by_bank),
        .last_deq_req_PR_by_bank     (last_deq_req_PR_by_bank),
        .last_deq_resp_ready_by_bank (last_deq_resp_ready_by_bank)
    );

    // 4 ns period
    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    // run limit
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the trace did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "run limit reached");
        end
    end

    // --------------------
    // helpers

    // one expected field against one DUT output
    task automatic check_field(input string name, input logic [7:0] exp_v,
                               input logic [7:0] got_v);
        assert (got_v == exp_v) else begin
            $display("mismatch at %0d ns: %s expected %0h got %0h", $time, name, exp_v, got_v);
            $display("Test FAILED");
            $fatal(1, "output check failed");
        end
    endtask

    // request fields of one line onto the DUT inputs
    task automatic drive_line(input int line);
        int               base;
        pr_t  [BANKS-1:0] prs;
        base = line * FIELD_COUNT;
        for (int b = 0; b < BANKS; b++) begin
            prs[b] = trace_mem[base + F_ENQ_PR + b][LOG_PR_COUNT-1:0];
        end
        next_enq_req_valid_by_bank <= trace_mem[base + F_ENQ_VALID][BANKS-1:0];
        next_enq_req_PR_by_bank    <= prs;
        next_deq_req_valid_by_bank <= trace_mem[base + F_DEQ_VALID][BANKS-1:0];
    endtask

    // pipeline flush after the last line
    task automatic drive_idle();
        next_enq_req_valid_by_bank <= '0;
        next_enq_req_PR_by_bank    <= '0;
        next_deq_req_valid_by_bank <= '0;
    endtask

    // age the two-deep delay and load the newest line
    task automatic shift_expected(input int line);
        int base;
        base = line * FIELD_COUNT;
        exp_ack_q[1]   = exp_ack_q[0];
        exp_head_q[1]  = exp_head_q[0];
        exp_ready_q[1] = exp_ready_q[0];
        exp_live_q[1]  = exp_live_q[0];
        exp_live_q[0]  = (line < LINE_COUNT);
        if (line < LINE_COUNT) begin
            exp_ack_q[0]   = trace_mem[base + F_ACK][BANKS-1:0];
            exp_ready_q[0] = trace_mem[base + F_READY][BANKS-1:0];
            for (int b = 0; b < BANKS; b++) begin
                exp_head_q[0][b] = trace_mem[base + F_HEAD + b][LOG_PR_COUNT-1:0];
            end
        end
    endtask

    // older line against the registered outputs
    task automatic check_outputs();
        for (int b = 0; b < BANKS; b++) begin
            check_field($sformatf("last_enq_resp_ack_by_bank[%0d]", b),
                        8'(exp_ack_q[1][b]), 8'(last_enq_resp_ack_by_bank[b]));
            check_field($sformatf("last_deq_req_PR_by_bank[%0d]", b),
                        8'(exp_head_q[1][b]), 8'(last_deq_req_PR_by_bank[b]));
            check_field($sformatf("last_deq_resp_ready_by_bank[%0d]", b),
                        8'(exp_ready_q[1][b]), 8'(last_deq_resp_ready_by_bank[b]));
        end
    endtask

    // --------------------
    // main sequence

    initial begin
        nRST                       = 1'b0;
        next_enq_req_valid_by_bank = '0;
        next_enq_req_PR_by_bank    = '0;
        next_deq_req_valid_by_bank = '0;
        for (int i = 0; i < 2; i++) begin
            exp_ack_q[i]   = '0;
            exp_head_q[i]  = '0;
            exp_ready_q[i] = '0;
            exp_live_q[i]  = 1'b0;
        end
        $readmemh("free_list_trace.txt", trace_mem);

        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        // line n goes in at edge n, its results sit in the last_ regs after edge n+2
        for (int cyc = 0; cyc < LINE_COUNT + 2; cyc++) begin
            @(posedge CLK);
            if (cyc < LINE_COUNT) begin
                drive_line(cyc);
            end else begin
                drive_idle();
            end
            @(negedge CLK);
            if (exp_live_q[1]) begin
                check_outputs();
            end
            shift_expected(cyc);
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- free_list_trace.txt
// ev pr0 pr1 pr2 pr3 dv | ack head0 head1 head2 head3 ready, all hex
// bit b of a valid, ack or ready mask is bank b, head is the PR taken by that line
// drain banks 0 and 1 from the reset fill
0 00 00 00 00 3 0 20 21 22 23 F
0 00 00 00 00 3 0 24 25 22 23 F
0 00 00 00 00 3 0 28 29 22 23 F
0 00 00 00 00 3 0 2C 2D 22 23 F
0 00 00 00 00 3 0 30 31 22 23 F
0 00 00 00 00 3 0 34 35 22 23 F
0 00 00 00 00 3 0 38 39 22 23 F
0 00 00 00 00 3 0 3C 3D 22 23 F
// dequeue on empty banks
0 00 00 00 00 3 0 00 00 22 23 C
0 00 00 00 00 1 0 00 00 22 23 C
// push and pop into empty bank 0, then free PRs back
1 20 00 00 00 1 1 00 00 22 23 C
3 2C 2D 00 00 0 3 20 00 22 23 D
2 00 21 00 00 0 2 20 2D 22 23 F
2 00 35 00 00 0 2 20 2D 22 23 F
0 00 00 00 00 3 0 20 2D 22 23 F
2 00 39 00 00 3 2 2C 21 22 23 F
0 00 00 00 00 3 0 00 35 22 23 E
0 00 00 00 00 2 0 00 39 22 23 E
0 00 00 00 00 2 0 00 00 22 23 C
// mixed traffic in all four banks
3 24 25 00 00 C 3 00 00 22 23 C
6 00 29 22 00 B 6 24 25 26 27 F
9 28 00 00 23 6 9 00 29 26 2B E
0 00 00 00 00 F 0 28 00 2A 2B D
// bank 2 drains to the freed 22, bank 3 swaps entries then fills
8 00 00 00 27 C 8 00 00 2E 2F C
8 00 00 00 2B C 8 00 00 32 33 C
8 00 00 00 2F C 8 00 00 36 37 C
8 00 00 00 33 C 8 00 00 3A 3B C
8 00 00 00 37 C 8 00 00 3E 3F C
8 00 00 00 3B 4 8 00 00 22 23 C
8 00 00 00 27 4 8 00 00 00 23 8
8 00 00 00 2B 0 8 00 00 00 23 8
8 00 00 00 2F 0 8 00 00 00 23 8
8 00 00 00 33 0 8 00 00 00 23 8
8 00 00 00 37 0 8 00 00 00 23 8
8 00 00 00 3B 0 8 00 00 00 23 8
8 00 00 00 23 0 8 00 00 00 23 8
8 00 00 00 27 0 8 00 00 00 23 8
8 00 00 00 2B 0 8 00 00 00 23 8
// bank 3 full, 3F dropped
8 00 00 00 3F 0 0 00 00 00 23 8
// drain all 16 entries of bank 3
0 00 00 00 00 8 0 00 00 00 23 8
0 00 00 00 00 8 0 00 00 00 27 8
0 00 00 00 00 8 0 00 00 00 2B 8
0 00 00 00 00 8 0 00 00 00 2F 8
0 00 00 00 00 8 0 00 00 00 33 8
0 00 00 00 00 8 0 00 00 00 37 8
0 00 00 00 00 8 0 00 00 00 3B 8
0 00 00 00 00 8 0 00 00 00 27 8
0 00 00 00 00 8 0 00 00 00 2B 8
0 00 00 00 00 8 0 00 00 00 2F 8
0 00 00 00 00 8 0 00 00 00 33 8
0 00 00 00 00 8 0 00 00 00 37 8
0 00 00 00 00 8 0 00 00 00 3B 8
0 00 00 00 00 8 0 00 00 00 23 8
0 00 00 00 00 8 0 00 00 00 27 8
0 00 00 00 00 8 0 00 00 00 2B 8
0 00 00 00 00 8 0 00 00 00 23 0
0 00 00 00 00 0 0 00 00 00 23 0

//--- compile.f
core_types_pkg.sv
free_list_pkg.sv
free_list.sv
free_list_wrapper.sv
tb_free_list_wrapper.sv

//--- run.sh
#!/bin/sh
# build the free list testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/100ps -f compile.f \
    --top-module tb_free_list_wrapper -o tb_free_list_wrapper &&
./obj_dir/tb_free_list_wrapper | tee /dev/stderr | grep -q "Test OK" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
